//--- verilog.f
source/aluPkg.sv
source/regFile.sv
source/barrelShifter.sv
source/claAdder.sv
source/alu.sv
source/execCtrl.sv
source/execUnit.sv
tests/execUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module execUnitTb -f verilog.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: build or simulation failed"; exit 1; }

//--- tests/execUnitTb.sv
// Testbench for the execute unit, self-checking against a register model
// The model is updated as each valid instruction is sampled by the DUT
// Results are compared one edge later, when the DUT outputs are stable
// Random instructions use $random with a fixed seed of 72
module execUnitTb import aluPkg::*; ();

    // Rough cycle count of all tests, doubled for the timeout
    localparam int budgetCycles  = 5 + 20 + 40 + 160 + 40 + 150 + 600 + 6 * 5;
    localparam int watchdogTime  = 2 * budgetCycles * 10;

    logic        clk = 1'b0;
    logic        rstN;
    logic        instrValid;
    logic [15:0] instr;
    logic        resultValid;
    logic [15:0] result;
    logic        zero;
    logic        neg;
    logic        ofl;
    logic        cout;

    logic [15:0] model [8];  // Expected register contents
    logic [19:0] pendExp;    // {result, zero, neg, ofl, cout}
    logic        pendValid;
    logic        afterReset;
    logic [31:0] rnd;
    integer      seed;
    string       curTest = "reset";
    int          errCount = 0;
    int          checkCount = 0;
    int          testCount = 0;
    int          startErrs;

    execUnit u_execUnit (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .resultValid(resultValid), .result(result), .zero(zero), .neg(neg),
        .ofl(ofl), .cout(cout)
    );

    always #5 clk = ~clk; // Period 10

    // Expected result and flags from the instruction and two register values
    function automatic logic [19:0] expectedOf(input logic [15:0] w, input logic [15:0] rA,
                                               input logic [15:0] rB);
        logic        isImm;
        logic        ia;
        logic        ib;
        logic        isCmp;
        logic        ovf;
        logic [3:0]  op;
        logic [3:0]  amt;
        logic [15:0] b;
        logic [15:0] aP;
        logic [15:0] bP;
        logic [15:0] sum;
        logic [15:0] rev;
        logic [15:0] res;
        logic [16:0] full;
        logic [31:0] dbl;
        isImm = w[15];
        op    = w[14:11];
        b     = isImm ? {{11{w[4]}}, w[4:0]} : rB;
        ia    = isImm ? 1'b0 : w[1];
        ib    = isImm ? 1'b0 : w[0];
        aP    = ia ? ~rA : rA;
        bP    = ib ? ~b : b;
        isCmp = (op == opSeq) || (op == opSlt) || (op == opSle);
        if (isCmp) begin
            full = {1'b0, rA} + {1'b0, ~b} + 17'd1; // A minus B, raw operands
        end else begin
            full = {1'b0, aP} + {1'b0, bP} + {16'b0, ib};
        end
        sum = full[15:0];
        // Same-sign addends with a sum of the other sign
        ovf = (op == opAdd) && (aP[15] == bP[15]) && (sum[15] != aP[15]);
        amt = bP[3:0];
        dbl = {aP, aP} << amt; // Top half is the rotate
        for (int i = 0; i < 16; i++) begin
            rev[i] = rA[15-i];
        end
        case (op)
            opRol:   res = dbl[31:16];
            opSll:   res = aP << amt;
            opSra:   res = $signed(aP) >>> amt;
            opSrl:   res = aP >> amt;
            opAdd:   res = sum;
            opAnd:   res = aP & bP;
            opOr:    res = aP | bP;
            opXor:   res = aP ^ bP;
            opSeq:   res = {15'b0, rA == b};
            opSlt:   res = {15'b0, $signed(rA) < $signed(b)};
            opSle:   res = {15'b0, $signed(rA) <= $signed(b)};
            opPassB: res = bP;
            opBtr:   res = rev;
            default: res = 16'h0000;
        endcase
        return {res, sum == 16'h0000, sum[15], ovf, full[16]};
    endfunction

    function automatic logic [15:0] rWord(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [2:0] rt,
                                          input logic ia, input logic ib);
        return {1'b0, op, rd, rs, rt, ia, ib};
    endfunction

    function automatic logic [15:0] iWord(input logic [3:0] op, input logic [2:0] rd,
                                          input logic [2:0] rs, input logic [4:0] imm);
        return {1'b1, op, rd, rs, imm};
    endfunction

    // Compare process, owns the model
    always @(posedge clk) begin
        if (!rstN) begin
            pendValid  = 1'b0;
            afterReset = 1'b1;
            for (int i = 0; i < 8; i++) begin
                model[i] = 16'h0000;
            end
        end else begin
            if (afterReset) begin // Outputs still at reset values
                checkCount++;
                if ({result, zero, neg, ofl, cout} !== 20'h00000) begin
                    $display("CHECK FAILED %s: expected %h, actual %h", curTest, 20'h00000,
                             {result, zero, neg, ofl, cout});
                    errCount++;
                end
                afterReset = 1'b0;
            end
            if (pendValid) begin
                checkCount++;
                if (resultValid !== 1'b1) begin
                    $display("Test %s: resultValid missing after a valid instruction", curTest);
                    errCount++;
                end else if ({result, zero, neg, ofl, cout} !== pendExp) begin
                    $display("CHECK FAILED %s: expected %h, actual %h", curTest, pendExp,
                             {result, zero, neg, ofl, cout});
                    errCount++;
                end
            end else if (resultValid !== 1'b0) begin
                $display("Test %s: resultValid high with no instruction issued", curTest);
                errCount++;
            end
            if (instrValid) begin // Sampled now by the DUT too
                pendExp = expectedOf(instr, model[instr[7:5]], model[instr[4:2]]);
                model[instr[10:8]] = pendExp[19:4];
                pendValid = 1'b1;
            end else begin
                pendValid = 1'b0;
            end
        end
    end

    task automatic issue(input logic [15:0] w);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= w;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    // Builds any 16-bit value in rd, a nibble at a time
    task automatic loadReg(input logic [2:0] rd, input logic [15:0] v);
        issue(iWord(opPassB, rd, 3'd0, {1'b0, v[15:12]}));
        for (int n = 2; n >= 0; n--) begin
            issue(iWord(opSll, rd, rd, 5'd4));
            issue(iWord(opOr, rd, rd, {1'b0, v[n*4 +: 4]}));
        end
    endtask

    task automatic startTest(input string name);
        @(negedge clk); // Away from the sampling edge
        curTest   = name;
        startErrs = errCount;
    endtask

    task automatic finishTest();
        repeat (3) idleCycle(); // Let the last compare happen
        @(negedge clk);
        testCount++;
        $display("Test %-8s %s, %0d errors", curTest,
                 (errCount == startErrs) ? "ok" : "failed", errCount - startErrs);
    endtask

    task automatic cmpPair(input logic [15:0] a, input logic [15:0] b);
        loadReg(3'd1, a);
        loadReg(3'd2, b);
        issue(rWord(opSeq, 3'd3, 3'd1, 3'd2, 1'b0, 1'b0));
        issue(rWord(opSlt, 3'd3, 3'd1, 3'd2, 1'b0, 1'b0));
        issue(rWord(opSle, 3'd3, 3'd1, 3'd2, 1'b1, 1'b1)); // Inversion ignored
        issue(rWord(opSlt, 3'd3, 3'd2, 3'd1, 1'b1, 1'b0));
        issue(rWord(opSle, 3'd3, 3'd2, 3'd1, 1'b0, 1'b0));
    endtask

    initial begin
        seed       = 72;
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        instr      <= 16'h0000;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        startTest("reset");
        repeat (3) idleCycle();
        issue(rWord(opAdd, 3'd1, 3'd0, 3'd0, 1'b0, 1'b0)); // r0 + r0
        finishTest();

        startTest("add");
        issue(iWord(opPassB, 3'd1, 3'd0, 5'h0F)); // 15
        issue(iWord(opPassB, 3'd2, 3'd0, 5'h10)); // -16
        issue(rWord(opAdd, 3'd3, 3'd1, 3'd2, 1'b0, 1'b0));
        issue(rWord(opAdd, 3'd3, 3'd1, 3'd2, 1'b0, 1'b1)); // Subtract
        issue(iWord(opAdd, 3'd3, 3'd2, 5'h1F));
        loadReg(3'd4, 16'h7FFF);
        loadReg(3'd5, 16'h8000);
        issue(iWord(opAdd, 3'd6, 3'd4, 5'd1));              // Positive overflow
        issue(rWord(opAdd, 3'd6, 3'd5, 3'd5, 1'b0, 1'b0));  // Negative overflow, zero sum
        issue(rWord(opAdd, 3'd6, 3'd5, 3'd4, 1'b0, 1'b1));  // 0x8000 - 0x7FFF
        issue(rWord(opAdd, 3'd6, 3'd4, 3'd4, 1'b0, 1'b1));  // Equal, zero and carry
        issue(rWord(opXor, 3'd6, 3'd4, 3'd5, 1'b0, 1'b0));  // No ofl here
        finishTest();

        startTest("shift");
        loadReg(3'd1, 16'h8C35);
        loadReg(3'd2, 16'h5A0F);
        for (int p = 1; p <= 2; p++) begin
            for (int m = 0; m < 4; m++) begin
                for (int k = 0; k < 16; k++) begin
                    issue(iWord({2'b00, m[1:0]}, 3'd4, p[2:0], {1'b0, k[3:0]}));
                end
            end
        end
        issue(rWord(opRol, 3'd4, 3'd1, 3'd2, 1'b0, 1'b0)); // Amount from a register
        issue(rWord(opSra, 3'd4, 3'd1, 3'd2, 1'b1, 1'b1));
        finishTest();

        startTest("logic");
        loadReg(3'd1, 16'hA5C3);
        loadReg(3'd2, 16'h3C69);
        for (int o = 5; o <= 7; o++) begin
            for (int v = 0; v < 4; v++) begin
                issue(rWord(o[3:0], 3'd3, 3'd1, 3'd2, v[1], v[0]));
            end
        end
        issue(rWord(opBtr, 3'd3, 3'd1, 3'd2, 1'b1, 1'b0)); // Reverses the raw A
        issue(rWord(4'b1000, 3'd3, 3'd1, 3'd2, 1'b0, 1'b0));
        issue(rWord(4'b1101, 3'd3, 3'd1, 3'd2, 1'b1, 1'b0));
        issue(iWord(4'b1110, 3'd3, 3'd1, 5'h05));
        finishTest();

        startTest("compare");
        cmpPair(16'h7FFF, 16'h8000); // Difference overflows
        cmpPair(16'h8000, 16'h7FFF);
        cmpPair(16'h0005, 16'h0005);
        cmpPair(16'hFFFF, 16'h0001);
        cmpPair(16'h8000, 16'h8000);
        cmpPair(16'h1234, 16'h1233);
        cmpPair(16'h8000, 16'h0001);
        finishTest();

        startTest("random");
        repeat (300) begin
            rnd = $random(seed);
            issue(rnd[15:0]);
            if (rnd[17:16] == 2'b00) begin
                idleCycle(); // Occasional gap
            end
        end
        finishTest();

        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogTime);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- source/execUnit.sv
// Top of the execute subsystem, instances and wires only
// Accepts one instruction per edge with instrValid high, no back-pressure
// Result and flags appear one cycle later with a resultValid pulse
module execUnit import aluPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  logic [dataWidth-1:0] instr,
    output logic                 resultValid,
    output logic [dataWidth-1:0] result,
    output logic                 zero,
    output logic                 neg,
    output logic                 ofl,
    output logic                 cout
);

    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [regAddrWidth-1:0] wrAddr;
    logic [dataWidth-1:0]    rdDataA; // Straight to the ALU
    logic [dataWidth-1:0]    rdDataB; // Through the B mux
    logic [dataWidth-1:0]    inB;
    logic [dataWidth-1:0]    aluOut;  // Also the write-back data
    logic [operWidth-1:0]    aluOper;
    logic                    invA;
    logic                    invB;
    logic                    wrEn;
    logic                    aluZero;
    logic                    aluNeg;
    logic                    aluOfl;
    logic                    aluCout;

    execCtrl uCtrl (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .rdDataB     (rdDataB),
        .aluOut      (aluOut),
        .aluZero     (aluZero),
        .aluNeg      (aluNeg),
        .aluOfl      (aluOfl),
        .aluCout     (aluCout),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .inB         (inB),
        .aluOper     (aluOper),
        .invA        (invA),
        .invB        (invB),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .resultValid (resultValid),
        .result      (result),
        .zero        (zero),
        .neg         (neg),
        .ofl         (ofl),
        .cout        (cout)
    );

    regFile uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .rsAddr  (rsAddr),
        .rtAddr  (rtAddr),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (aluOut),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    alu uAlu (
        .inA    (rdDataA),
        .inB    (inB),
        .oper   (aluOper),
        .invA   (invA),
        .invB   (invB),
        .aluOut (aluOut),
        .zero   (aluZero),
        .neg    (aluNeg),
        .ofl    (aluOfl),
        .cout   (aluCout)
    );

endmodule

//--- source/execCtrl.sv
// Decode, operand B select, write-back control and the result register
// Write-back is combinational, so rd is updated at the same edge as the result
// One registered stage; resultValid pulses one cycle per valid instruction
// I-form forces invA and invB low and sign-extends the 5-bit immediate
module execCtrl import aluPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,
    input  instrWord                instr,
    input  logic [dataWidth-1:0]    rdDataB,
    input  logic [dataWidth-1:0]    aluOut,
    input  logic                    aluZero,
    input  logic                    aluNeg,
    input  logic                    aluOfl,
    input  logic                    aluCout,
    output logic [regAddrWidth-1:0] rsAddr,
    output logic [regAddrWidth-1:0] rtAddr,
    output logic [dataWidth-1:0]    inB,
    output logic [operWidth-1:0]    aluOper,
    output logic                    invA,
    output logic                    invB,
    output logic                    wrEn,
    output logic [regAddrWidth-1:0] wrAddr,
    output logic                    resultValid,
    output logic [dataWidth-1:0]    result,
    output logic                    zero,
    output logic                    neg,
    output logic                    ofl,
    output logic                    cout
);

    logic                 isImm;
    logic [dataWidth-1:0] immExt; // Sign-extended immediate

    assign isImm   = instr.rForm.isImm; // Same bit in both views
    assign immExt  = {{(dataWidth-immWidth){instr.iForm.imm[immWidth-1]}}, instr.iForm.imm};

    assign rsAddr  = instr.rForm.rs;
    assign rtAddr  = instr.rForm.rt; // Ignored downstream in I-form
    assign aluOper = instr.rForm.oper;
    assign inB     = isImm ? immExt : rdDataB;
    assign invA    = isImm ? 1'b0 : instr.rForm.invA;
    assign invB    = isImm ? 1'b0 : instr.rForm.invB;

    assign wrEn    = instrValid; // Every operation writes rd
    assign wrAddr  = instr.rForm.rd;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            result      <= '0;
            zero        <= 1'b0;
            neg         <= 1'b0;
            ofl         <= 1'b0;
            cout        <= 1'b0;
        end else begin
            resultValid <= instrValid; // One-cycle pulse
            if (instrValid) begin
                result <= aluOut;
                zero   <= aluZero;
                neg    <= aluNeg;
                ofl    <= aluOfl;
                cout   <= aluCout;
            end
        end
    end

    // On an add the registered flags describe the registered sum
    addFlagsMatch: assert property (@(posedge clk) disable iff (!rstN)
        resultValid && $past(aluOper) == opAdd
            |-> (zero == (result == '0)) && (neg == result[dataWidth-1]))
        else $error("add flags disagree with the registered result");

endmodule

//--- source/alu.sv
// 16-bit ALU, purely combinational
// Carry-in follows invB, so opAdd with invB set subtracts
// Compares ignore invA and invB and always compute A minus B
// zero, neg and cout come from the adder sum for every operation
// ofl is reported for opAdd only; undefined codes return zero
module alu import aluPkg::*; (
    input  logic [dataWidth-1:0] inA,
    input  logic [dataWidth-1:0] inB,
    input  logic [operWidth-1:0] oper,
    input  logic                 invA,
    input  logic                 invB,
    output logic [dataWidth-1:0] aluOut,
    output logic                 zero,
    output logic                 neg,
    output logic                 ofl,
    output logic                 cout
);

    logic [dataWidth-1:0] aProc;  // A after optional inversion
    logic [dataWidth-1:0] bProc;  // B after optional inversion
    logic [dataWidth-1:0] addA;
    logic [dataWidth-1:0] addB;
    logic [dataWidth-1:0] addSum;
    logic [dataWidth-1:0] shOut;
    logic [dataWidth-1:0] btrOut; // inA reversed
    logic                 isCmp;  // SEQ, SLT or SLE
    logic                 addCin;
    logic                 addOfl; // Raw adder overflow
    logic                 slt;

    assign aProc = invA ? ~inA : inA;
    assign bProc = invB ? ~inB : inB;

    assign isCmp  = (oper == opSeq) || (oper == opSlt) || (oper == opSle);
    assign addA   = isCmp ? inA : aProc;
    assign addB   = isCmp ? ~inB : bProc; // Forced A - B for compares
    assign addCin = isCmp | invB;

    claAdder uAdder (
        .a    (addA),
        .b    (addB),
        .cin  (addCin),
        .sum  (addSum),
        .cout (cout),
        .ofl  (addOfl)
    );

    barrelShifter uShifter (
        .dataIn  (aProc),
        .shAmt   (bProc[shAmtWidth-1:0]), // Low bits of processed B
        .shMode  (oper[1:0]),             // Shift codes map straight to modes
        .dataOut (shOut)
    );

    always_comb begin
        for (int i = 0; i < dataWidth; i++) begin
            btrOut[i] = inA[dataWidth-1-i];
        end
    end

    assign zero = (addSum == '0);
    assign neg  = addSum[dataWidth-1];
    assign slt  = neg ^ addOfl; // Signed less-than, survives overflow
    assign ofl  = (oper == opAdd) ? addOfl : 1'b0;

    always_comb begin
        case (oper)
            opRol, opSll, opSra, opSrl: aluOut = shOut;
            opAdd:   aluOut = addSum;
            opAnd:   aluOut = aProc & bProc;
            opOr:    aluOut = aProc | bProc;
            opXor:   aluOut = aProc ^ bProc;
            opSeq:   aluOut = {{(dataWidth-1){1'b0}}, zero};
            opSlt:   aluOut = {{(dataWidth-1){1'b0}}, slt};
            opSle:   aluOut = {{(dataWidth-1){1'b0}}, slt | zero};
            opPassB: aluOut = bProc;
            opBtr:   aluOut = btrOut;
            default: aluOut = '0; // Undefined codes
        endcase
    end

    // Carry-based overflow matches the sign rule on opAdd and stays low elsewhere
    always_comb begin
        if (!$isunknown({addA, addB, oper})) begin
            oflMatchesSigns: assert (ofl == ((oper == opAdd)
                                     && (addA[dataWidth-1] == addB[dataWidth-1])
                                     && (addSum[dataWidth-1] != addA[dataWidth-1])))
                else $error("alu overflow flag disagrees with the operand signs");
        end
    end

endmodule

//--- source/claAdder.sv
// 16-bit two-level carry-lookahead adder, purely combinational
// Four 4-bit groups produce group generate and propagate
// ofl is signed overflow, carry into the top bit xor carry out
module claAdder import aluPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  logic                 cin,
    output logic [dataWidth-1:0] sum,
    output logic                 cout,
    output logic                 ofl
);

    logic [dataWidth-1:0] g;  // Bit generate
    logic [dataWidth-1:0] p;  // Bit propagate
    logic [dataWidth-1:0] c;  // Carry into each bit
    logic [3:0]           gg; // Group generate
    logic [3:0]           gp; // Group propagate
    logic [3:0]           gc; // Carry into each group

    assign g = a & b;
    assign p = a ^ b;

    for (genvar j = 0; j < 4; j++) begin : grp
        localparam int base = 4 * j; // Lowest bit of this group

        assign gp[j] = &p[base+3:base];
        assign gg[j] = g[base+3]
                     | (p[base+3] & g[base+2])
                     | (p[base+3] & p[base+2] & g[base+1])
                     | (p[base+3] & p[base+2] & p[base+1] & g[base]);

        // Carries inside the group from the group carry-in
        assign c[base]   = gc[j];
        assign c[base+1] = g[base] | (p[base] & gc[j]);
        assign c[base+2] = g[base+1] | (p[base+1] & g[base])
                         | (p[base+1] & p[base] & gc[j]);
        assign c[base+3] = g[base+2] | (p[base+2] & g[base+1])
                         | (p[base+2] & p[base+1] & g[base])
                         | (p[base+2] & p[base+1] & p[base] & gc[j]);
    end

    // Second lookahead level over the groups
    assign gc[0] = cin;
    assign gc[1] = gg[0] | (gp[0] & cin);
    assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & cin);
    assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                 | (gp[2] & gp[1] & gp[0] & cin);
    assign cout  = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                 | (gp[3] & gp[2] & gp[1] & gg[0])
                 | (gp[3] & gp[2] & gp[1] & gp[0] & cin);

    assign sum = p ^ c;
    assign ofl = c[dataWidth-1] ^ cout; // Top-bit carry disagrees

endmodule

//--- source/barrelShifter.sv
// Four-stage shift network, purely combinational
// shMode 00 rotate left, 01 shift left, 10 arithmetic right, 11 logical right
// Stages move by 1, 2, 4 and 8 bits, selected by the bits of shAmt
module barrelShifter import aluPkg::*; (
    input  logic [dataWidth-1:0]  dataIn,
    input  logic [shAmtWidth-1:0] shAmt,
    input  logic [1:0]            shMode,
    output logic [dataWidth-1:0]  dataOut
);

    logic [dataWidth-1:0] stage1; // After the 1-bit step
    logic [dataWidth-1:0] stage2; // After the 2-bit step
    logic [dataWidth-1:0] stage4; // After the 4-bit step
    logic [dataWidth-1:0] stage8; // After the 8-bit step

    // One fixed-distance move in the selected mode
    function automatic logic [dataWidth-1:0] shiftBy(
        input logic [dataWidth-1:0] d,
        input int                   n,
        input logic [1:0]           mode
    );
        case (mode)
            2'b00:   shiftBy = (d << n) | (d >> (dataWidth - n)); // Bits wrap around
            2'b01:   shiftBy = d << n;
            2'b10:   shiftBy = $signed(d) >>> n; // Sign bit fills in
            default: shiftBy = d >> n;
        endcase
    endfunction

    assign stage1  = shAmt[0] ? shiftBy(dataIn, 1, shMode) : dataIn;
    assign stage2  = shAmt[1] ? shiftBy(stage1, 2, shMode) : stage1;
    assign stage4  = shAmt[2] ? shiftBy(stage2, 4, shMode) : stage2;
    assign stage8  = shAmt[3] ? shiftBy(stage4, 8, shMode) : stage4;
    assign dataOut = stage8;

endmodule

//--- source/regFile.sv
// Eight 16-bit registers, two combinational read ports, one write port
// A write lands at the clock edge, so a read in the next cycle sees it
// No bypass from wrData to the read ports within the same cycle
// Reset clears every register
module regFile import aluPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,
    input  logic                    wrEn,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0]    wrData,
    output logic [dataWidth-1:0]    rdDataA,
    output logic [dataWidth-1:0]    rdDataB
);

    logic [dataWidth-1:0] regs [regCount]; // Architectural state

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0; // All registers start at zero
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData; // Write-back from the ALU
        end
    end

    assign rdDataA = regs[rsAddr]; // Feeds alu.inA directly
    assign rdDataB = regs[rtAddr]; // Goes through the B-operand mux

    // A write to an unknown address would corrupt the whole file
    wrAddrKnown: assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> !$isunknown(wrAddr))
        else $error("regFile write with unknown address");

endmodule

//--- source/aluPkg.sv
// Widths, operation codes and the instruction word shared by the execute unit
// The width is fixed at 16 because bit-reverse and the 4-bit shift field depend on it
// Codes 1000, 1101 and 1110 are undefined and make the ALU return zero
// Subtract is opAdd with invB set, since carry-in follows invB
package aluPkg;

    localparam int dataWidth    = 16; // One word
    localparam int regCount     = 8;
    localparam int regAddrWidth = 3;
    localparam int operWidth    = 4;
    localparam int immWidth     = 5;  // I-form immediate, sign-extended
    localparam int shAmtWidth   = 4;  // Enough for 0..15

    localparam logic [operWidth-1:0] opRol   = 4'b0000;
    localparam logic [operWidth-1:0] opSll   = 4'b0001;
    localparam logic [operWidth-1:0] opSra   = 4'b0010;
    localparam logic [operWidth-1:0] opSrl   = 4'b0011;
    localparam logic [operWidth-1:0] opAdd   = 4'b0100;
    localparam logic [operWidth-1:0] opAnd   = 4'b0101;
    localparam logic [operWidth-1:0] opOr    = 4'b0110;
    localparam logic [operWidth-1:0] opXor   = 4'b0111;
    localparam logic [operWidth-1:0] opSeq   = 4'b1001;
    localparam logic [operWidth-1:0] opSlt   = 4'b1010;
    localparam logic [operWidth-1:0] opPassB = 4'b1011;
    localparam logic [operWidth-1:0] opSle   = 4'b1100;
    localparam logic [operWidth-1:0] opBtr   = 4'b1111;

    // Same 16 bits, read as R-form or I-form depending on isImm
    typedef union packed {
        struct packed {
            logic                    isImm; // Low here
            logic [operWidth-1:0]    oper;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic                    invA;
            logic                    invB;
        } rForm;
        struct packed {
            logic                    isImm; // High here
            logic [operWidth-1:0]    oper;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] rs;
            logic [immWidth-1:0]     imm;   // Replaces rt, invA, invB
        } iForm;
    } instrWord;

endpackage
